// File: snes_bus_pkg.sv
package snes_bus_pkg;

  // strobe synchronizer length
  localparam int SYNC_DEPTH = 8;

  // cpu clock low this long means no console, about 1 ms
  localparam int SNES_DEAD_TIMEOUT = 96000;
  localparam int DEAD_CNT_W = 18;

  // one-cycle pulses first, then synchronized levels
  typedef struct packed {
    logic rd_start;
    logic rd_end;
    logic wr_end;
    logic cycle_start;
    logic cycle_end;
    logic cpu_clk;
    logic read_n;
    logic write_n;
  } snes_events_t;

endpackage

// File: mem_pkg.sv
package mem_pkg;

  localparam int ADDR_W = 24;
  localparam int ROM_ADDR_W = 23;
  localparam int RAM_ADDR_W = 19;
  localparam int DELAY_W = 4;

  // psram needs the extra cycle on slow parts
  localparam logic [DELAY_W-1:0] ROM_CYCLE_LEN = 4'd7;
  localparam logic [DELAY_W-1:0] RAM_CYCLE_LEN = 4'd5;

  // mcu addresses 0xe00000 to 0xe7ffff go to the sram
  localparam logic [4:0] RAM_REGION = 5'b11100;

  typedef struct packed {
    logic              rd;
    logic              wr;
    logic              word;
    logic [ADDR_W-1:0] addr;
    logic [15:0]       wdata;
  } mem_req_t;

  typedef enum logic [2:0] {
    ROM_IDLE,
    ROM_MCU_RD,
    ROM_MCU_WR,
    ROM_SA1_RD,
    ROM_DONE
  } rom_state_e;

  typedef enum logic [2:0] {
    RAM_IDLE,
    RAM_MCU_RD,
    RAM_MCU_WR,
    RAM_SA1_RD,
    RAM_SA1_WR,
    RAM_DONE
  } ram_state_e;

  // owner of the psram port held through the done cycle
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_MCU_RD,
    GRANT_MCU_WR,
    GRANT_SA1_RD
  } rom_grant_e;

endpackage

// File: snes_bus_monitor.sv
module snes_bus_monitor (
  input  logic                       CLK2,
  input  logic                       SNES_reset_strobe,
  input  logic                       snes_read_in,
  input  logic                       snes_write_in,
  input  logic                       snes_cpu_clk_in,
  output snes_bus_pkg::snes_events_t events,
  output logic                       snes_dead
);
  import snes_bus_pkg::*;

  logic [SYNC_DEPTH-1:0] read_sr;
  logic [SYNC_DEPTH-1:0] write_sr;
  logic [SYNC_DEPTH-1:0] clk_sr;
  logic [DEAD_CNT_W-1:0] dead_cnt;
  logic                  rd_end_q;
  logic                  wr_end_q;
  logic                  cpu_clk;

  // --------------------------------------------------------------------------
  // strobe synchronizers
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      read_sr  <= '1;
      write_sr <= '1;
      clk_sr   <= '0;
    end else begin
      read_sr  <= {read_sr[SYNC_DEPTH-2:0], snes_read_in};
      write_sr <= {write_sr[SYNC_DEPTH-2:0], snes_write_in};
      clk_sr   <= {clk_sr[SYNC_DEPTH-2:0], snes_cpu_clk_in};
    end
  end

  // rising edges of read and write need a glitch-free run first
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      rd_end_q <= 1'b0;
      wr_end_q <= 1'b0;
    end else begin
      rd_end_q <= ((read_sr[5:0] & read_sr[6:1]) == 6'b000001);
      wr_end_q <= ((write_sr[5:0] & write_sr[6:1]) == 6'b000001);
    end
  end

  assign cpu_clk = clk_sr[2] & clk_sr[1];

  always_comb begin
    events.rd_start    = ((read_sr[6:1] | read_sr[7:2]) == 6'b111100);
    events.rd_end      = rd_end_q;
    events.wr_end      = wr_end_q;
    events.cycle_start = ((clk_sr[7:2] & clk_sr[6:1]) == 6'b000011);
    events.cycle_end   = ((clk_sr[7:2] | clk_sr[6:1]) == 6'b111000);
    events.cpu_clk     = cpu_clk;
    events.read_n      = read_sr[2] & read_sr[1];
    events.write_n     = write_sr[2] & write_sr[1];
  end

  // --------------------------------------------------------------------------
  // dead console detector
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else begin
      if (cpu_clk) begin
        dead_cnt <= '0;
      end else if (dead_cnt != '1) begin
        dead_cnt <= dead_cnt + 1'b1;
      end
      // clock back, the ports see dead and cpu_clk together for one cycle
      if (cpu_clk) begin
        snes_dead <= 1'b0;
      end else if (dead_cnt > SNES_DEAD_TIMEOUT) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

// File: mem_req_latch.sv
module mem_req_latch (
  input  logic             CLK2,
  input  logic             SNES_reset_strobe,
  input  mem_pkg::mem_req_t req,
  input  logic             done,
  output logic             rd_pend,
  output logic             wr_pend,
  output logic             rdy,
  output mem_pkg::mem_req_t held
);
  import mem_pkg::*;

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end else if (req.rd) begin
      rd_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (req.wr) begin
      wr_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end
  end

  // address, data and word flag for the port
  always_ff @(posedge CLK2) begin
    if (req.rd || req.wr) begin
      held <= req;
    end
  end

  // a port's done pulse must always find something pending
  a_done_has_pend: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    done |-> !rdy && (rd_pend || wr_pend));

  a_rdy_not_pend: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    !(rdy && (rd_pend || wr_pend)));

endmodule

// File: rom_port.sv
module rom_port (
  input  logic                          CLK2,
  input  logic                          SNES_reset_strobe,
  input  snes_bus_pkg::snes_events_t    events,
  input  logic                          snes_dead,
  input  logic                          is_rom,
  input  logic [mem_pkg::ADDR_W-1:0]    snes_addr,
  input  logic                          sa1_rd_pend,
  input  mem_pkg::mem_req_t             sa1_held,
  input  logic                          mcu_rd_pend,
  input  logic                          mcu_wr_pend,
  input  mem_pkg::mem_req_t             mcu_held,
  input  logic [15:0]                   rom_data_in,
  output logic                          sa1_done,
  output logic                          mcu_done,
  output logic [mem_pkg::ROM_ADDR_W-1:0] rom_addr,
  output logic                          rom_we,
  output logic                          rom_bhe,
  output logic                          rom_ble,
  output logic [15:0]                   rom_data_out,
  output logic                          rom_data_oe,
  output logic [7:0]                    mcu_byte,
  output logic [15:0]                   sa1_word
);
  import mem_pkg::*;

  rom_state_e         state;
  rom_grant_e         grant;
  logic [DELAY_W-1:0] delay;
  logic [ADDR_W-1:0]  cur_addr;
  logic               free_slot;
  logic               word_en;

  assign free_slot = events.cycle_end | ~is_rom | snes_dead;

  // --------------------------------------------------------------------------
  // access FSM
  // --------------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe || (snes_dead && events.cpu_clk)) begin
      // console came back, pending flags stay so the access restarts
      state <= ROM_IDLE;
      grant <= GRANT_NONE;
      delay <= '0;
    end else begin
      case (state)
        ROM_IDLE: begin
          delay <= ROM_CYCLE_LEN;
          if (free_slot) begin
            if (sa1_rd_pend) begin
              state <= ROM_SA1_RD;
              grant <= GRANT_SA1_RD;
            end else if (mcu_rd_pend) begin
              state <= ROM_MCU_RD;
              grant <= GRANT_MCU_RD;
            end else if (mcu_wr_pend) begin
              state <= ROM_MCU_WR;
              grant <= GRANT_MCU_WR;
            end
          end
        end
        ROM_MCU_RD, ROM_MCU_WR, ROM_SA1_RD: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= ROM_DONE;
          end
        end
        default: begin
          state <= ROM_IDLE;
          grant <= GRANT_NONE;
        end
      endcase
    end
  end

  assign sa1_done = (state == ROM_DONE) && (grant == GRANT_SA1_RD);
  assign mcu_done = (state == ROM_DONE) &&
                    ((grant == GRANT_MCU_RD) || (grant == GRANT_MCU_WR));

  // address and byte lanes, odd byte lives in the low lane
  always_comb begin
    case (grant)
      GRANT_SA1_RD:               cur_addr = sa1_held.addr;
      GRANT_MCU_RD, GRANT_MCU_WR: cur_addr = mcu_held.addr;
      default:                    cur_addr = snes_addr;
    endcase
  end

  assign rom_addr = cur_addr[ADDR_W-1:1];
  assign word_en  = (grant == GRANT_SA1_RD) && sa1_held.word;
  assign rom_bhe  = cur_addr[0] & ~word_en;
  assign rom_ble  = ~cur_addr[0] & ~word_en;

  assign rom_we       = (state != ROM_MCU_WR);
  assign rom_data_oe  = (state == ROM_MCU_WR);
  assign rom_data_out = {mcu_held.wdata[7:0], mcu_held.wdata[7:0]};

  // read data, sampled every cycle of the access
  always_ff @(posedge CLK2) begin
    if (state == ROM_MCU_RD) begin
      mcu_byte <= cur_addr[0] ? rom_data_in[7:0] : rom_data_in[15:8];
    end
    if (state == ROM_SA1_RD) begin
      sa1_word <= cur_addr[0] ? rom_data_in : {rom_data_in[7:0], rom_data_in[15:8]};
    end
  end

  a_we_mcu_wr: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    !rom_we |-> mcu_wr_pend && (grant == GRANT_MCU_WR));

endmodule

// File: ram_port.sv
module ram_port (
  input  logic                          CLK2,
  input  logic                          SNES_reset_strobe,
  input  snes_bus_pkg::snes_events_t    events,
  input  logic                          snes_dead,
  input  logic                          is_saveram,
  input  logic [mem_pkg::ADDR_W-1:0]    snes_addr,
  input  logic                          sa1_rd_pend,
  input  logic                          sa1_wr_pend,
  input  mem_pkg::mem_req_t             sa1_held,
  input  logic                          mcu_rd_pend,
  input  logic                          mcu_wr_pend,
  input  mem_pkg::mem_req_t             mcu_held,
  input  logic [7:0]                    ram_data_in,
  output logic                          sa1_done,
  output logic                          mcu_done,
  output logic [mem_pkg::RAM_ADDR_W-1:0] ram_addr,
  output logic                          ram_we,
  output logic [7:0]                    ram_data_out,
  output logic                          ram_data_oe,
  output logic [7:0]                    mcu_byte,
  output logic [7:0]                    sa1_byte
);
  import mem_pkg::*;

  ram_state_e         state;
  logic [DELAY_W-1:0] delay;
  logic               sa1_owner;
  logic               free_slot;
  logic               wr_state;

  assign free_slot = events.cycle_end | ~is_saveram | snes_dead;

  always_ff @(posedge CLK2) begin
    if (SNES_reset_strobe || (snes_dead && events.cpu_clk)) begin
      state     <= RAM_IDLE;
      sa1_owner <= 1'b0;
      delay     <= '0;
    end else begin
      case (state)
        RAM_IDLE: begin
          delay     <= RAM_CYCLE_LEN;
          sa1_owner <= sa1_rd_pend | sa1_wr_pend;
          if (free_slot) begin
            if (sa1_rd_pend) begin
              state <= RAM_SA1_RD;
            end else if (sa1_wr_pend) begin
              state <= RAM_SA1_WR;
            end else if (mcu_rd_pend) begin
              state <= RAM_MCU_RD;
            end else if (mcu_wr_pend) begin
              state <= RAM_MCU_WR;
            end
          end
        end
        RAM_MCU_RD, RAM_MCU_WR, RAM_SA1_RD, RAM_SA1_WR: begin
          delay <= delay - 1'b1;
          if (delay == '0) begin
            state <= RAM_DONE;
          end
        end
        default: state <= RAM_IDLE;
      endcase
    end
  end

  assign sa1_done = (state == RAM_DONE) && sa1_owner;
  assign mcu_done = (state == RAM_DONE) && !sa1_owner;

  // snes mapped address whenever the port is idle
  always_comb begin
    if (state == RAM_IDLE) begin
      ram_addr = snes_addr[RAM_ADDR_W-1:0];
    end else if (sa1_owner) begin
      ram_addr = sa1_held.addr[RAM_ADDR_W-1:0];
    end else begin
      ram_addr = mcu_held.addr[RAM_ADDR_W-1:0];
    end
  end

  assign wr_state     = (state == RAM_MCU_WR) || (state == RAM_SA1_WR);
  assign ram_we       = ~wr_state;
  assign ram_data_oe  = wr_state;
  assign ram_data_out = sa1_owner ? sa1_held.wdata[7:0] : mcu_held.wdata[7:0];

  always_ff @(posedge CLK2) begin
    if (state == RAM_MCU_RD) begin
      mcu_byte <= ram_data_in;
    end
    if (state == RAM_SA1_RD) begin
      sa1_byte <= ram_data_in;
    end
  end

  a_oe_is_write: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    ram_data_oe |-> !ram_we && (sa1_wr_pend || mcu_wr_pend));

endmodule

// File: mcu_port.sv
module mcu_port (
  input  logic              CLK2,
  input  logic              SNES_reset_strobe,
  input  mem_pkg::mem_req_t mcu_req,
  output mem_pkg::mem_req_t rom_req,
  output mem_pkg::mem_req_t ram_req,
  input  logic              rom_rdy,
  input  logic              ram_rdy,
  input  logic              rom_done,
  input  logic              ram_done,
  input  logic [7:0]        rom_byte,
  input  logic [7:0]        ram_byte,
  output logic              mcu_rdy,
  output logic [7:0]        mcu_rdata
);
  import mem_pkg::*;

  logic is_ram;

  assign is_ram = (mcu_req.addr[ADDR_W-1 -: 5] == RAM_REGION);

  // same request to both sides, strobes only to the chosen one
  always_comb begin
    rom_req    = mcu_req;
    ram_req    = mcu_req;
    rom_req.rd = mcu_req.rd & ~is_ram;
    rom_req.wr = mcu_req.wr & ~is_ram;
    ram_req.rd = mcu_req.rd & is_ram;
    ram_req.wr = mcu_req.wr & is_ram;
  end

  assign mcu_rdy = rom_rdy & ram_rdy;

  always_ff @(posedge CLK2) begin
    if (rom_done) begin
      mcu_rdata <= rom_byte;
    end else if (ram_done) begin
      mcu_rdata <= ram_byte;
    end
  end

  // one request at a time, and only while both sides are idle
  a_one_target: assert property (@(posedge CLK2) disable iff (SNES_reset_strobe)
    (rom_req.rd || rom_req.wr || ram_req.rd || ram_req.wr) |->
      mcu_rdy && !((rom_req.rd || rom_req.wr) && (ram_req.rd || ram_req.wr)));

endmodule

// File: cart_mem_arbiter.sv
module cart_mem_arbiter (
  input  logic                           CLK2,
  input  logic                           SNES_reset_strobe,
  input  logic                           snes_read_in,
  input  logic                           snes_write_in,
  input  logic                           snes_cpu_clk_in,
  input  logic [mem_pkg::ADDR_W-1:0]     snes_map,
  input  logic                           is_rom,
  input  logic                           is_saveram,
  input  logic                           rom_hit,
  input  mem_pkg::mem_req_t              mcu_req,
  input  mem_pkg::mem_req_t              sa1_rom_req,
  input  mem_pkg::mem_req_t              sa1_ram_req,
  input  logic [15:0]                    rom_data_in,
  input  logic [7:0]                     ram_data_in,
  output logic [mem_pkg::ROM_ADDR_W-1:0] rom_addr,
  output logic                           rom_we,
  output logic                           rom_bhe,
  output logic                           rom_ble,
  output logic [15:0]                    rom_data_out,
  output logic                           rom_data_oe,
  output logic [mem_pkg::RAM_ADDR_W-1:0] ram_addr,
  output logic                           ram_we,
  output logic [7:0]                     ram_data_out,
  output logic                           ram_data_oe,
  output logic                           mcu_rdy,
  output logic [7:0]                     mcu_rdata,
  output logic                           sa1_rom_rdy,
  output logic [15:0]                    sa1_rom_rdata,
  output logic                           sa1_ram_rdy,
  output logic [7:0]                     sa1_ram_rdata,
  output logic                           snes_dead
);
  import snes_bus_pkg::*;
  import mem_pkg::*;

  snes_events_t events;
  mem_req_t     mcu_rom_req;
  mem_req_t     mcu_ram_req;
  mem_req_t     mcu_rom_held;
  mem_req_t     mcu_ram_held;
  mem_req_t     sa1_rom_held;
  mem_req_t     sa1_ram_held;
  logic         mcu_rom_rd_pend;
  logic         mcu_rom_wr_pend;
  logic         mcu_ram_rd_pend;
  logic         mcu_ram_wr_pend;
  logic         sa1_rom_rd_pend;
  logic         sa1_ram_rd_pend;
  logic         sa1_ram_wr_pend;
  logic         mcu_rom_rdy;
  logic         mcu_ram_rdy;
  logic         rom_mcu_done;
  logic         rom_sa1_done;
  logic         ram_mcu_done;
  logic         ram_sa1_done;
  logic [7:0]   rom_mcu_byte;
  logic [7:0]   ram_mcu_byte;

  snes_bus_monitor u_snes_bus_monitor (
    .CLK2, .SNES_reset_strobe, .snes_read_in, .snes_write_in, .snes_cpu_clk_in,
    .events, .snes_dead
  );

  mcu_port u_mcu_port (
    .CLK2, .SNES_reset_strobe, .mcu_req,
    .rom_req(mcu_rom_req), .ram_req(mcu_ram_req),
    .rom_rdy(mcu_rom_rdy), .ram_rdy(mcu_ram_rdy),
    .rom_done(rom_mcu_done), .ram_done(ram_mcu_done),
    .rom_byte(rom_mcu_byte), .ram_byte(ram_mcu_byte),
    .mcu_rdy, .mcu_rdata
  );

  // --------------------------------------------------------------------------
  // request latches
  // --------------------------------------------------------------------------
  mem_req_latch u_mcu_rom_latch (
    .CLK2, .SNES_reset_strobe, .req(mcu_rom_req), .done(rom_mcu_done),
    .rd_pend(mcu_rom_rd_pend), .wr_pend(mcu_rom_wr_pend),
    .rdy(mcu_rom_rdy), .held(mcu_rom_held)
  );

  // sa1 never writes the psram
  mem_req_latch u_sa1_rom_latch (
    .CLK2, .SNES_reset_strobe, .req(sa1_rom_req), .done(rom_sa1_done),
    .rd_pend(sa1_rom_rd_pend), .wr_pend(),
    .rdy(sa1_rom_rdy), .held(sa1_rom_held)
  );

  mem_req_latch u_mcu_ram_latch (
    .CLK2, .SNES_reset_strobe, .req(mcu_ram_req), .done(ram_mcu_done),
    .rd_pend(mcu_ram_rd_pend), .wr_pend(mcu_ram_wr_pend),
    .rdy(mcu_ram_rdy), .held(mcu_ram_held)
  );

  mem_req_latch u_sa1_ram_latch (
    .CLK2, .SNES_reset_strobe, .req(sa1_ram_req), .done(ram_sa1_done),
    .rd_pend(sa1_ram_rd_pend), .wr_pend(sa1_ram_wr_pend),
    .rdy(sa1_ram_rdy), .held(sa1_ram_held)
  );

  // --------------------------------------------------------------------------
  // memory ports
  // --------------------------------------------------------------------------
  rom_port u_rom_port (
    .CLK2, .SNES_reset_strobe, .events, .snes_dead, .is_rom,
    .snes_addr(snes_map),
    .sa1_rd_pend(sa1_rom_rd_pend), .sa1_held(sa1_rom_held),
    .mcu_rd_pend(mcu_rom_rd_pend), .mcu_wr_pend(mcu_rom_wr_pend),
    .mcu_held(mcu_rom_held), .rom_data_in,
    .sa1_done(rom_sa1_done), .mcu_done(rom_mcu_done),
    .rom_addr, .rom_we, .rom_bhe, .rom_ble, .rom_data_out, .rom_data_oe,
    .mcu_byte(rom_mcu_byte), .sa1_word(sa1_rom_rdata)
  );

  ram_port u_ram_port (
    .CLK2, .SNES_reset_strobe, .events, .snes_dead,
    .is_saveram, .snes_addr(snes_map),
    .sa1_rd_pend(sa1_ram_rd_pend), .sa1_wr_pend(sa1_ram_wr_pend),
    .sa1_held(sa1_ram_held),
    .mcu_rd_pend(mcu_ram_rd_pend), .mcu_wr_pend(mcu_ram_wr_pend),
    .mcu_held(mcu_ram_held), .ram_data_in,
    .sa1_done(ram_sa1_done), .mcu_done(ram_mcu_done),
    .ram_addr, .ram_we, .ram_data_out, .ram_data_oe,
    .mcu_byte(ram_mcu_byte), .sa1_byte(sa1_ram_rdata)
  );

endmodule

// File: tb_clock.sv
module tb_clock #(
  parameter int PERIOD = 4,
  parameter int RESET_CYCLES = 3
) (
  output logic CLK2,
  output logic SNES_reset_strobe
);

  initial begin
    CLK2 = 1'b0;
    forever #(PERIOD / 2) CLK2 = ~CLK2;
  end

  // reset held over the first few rising edges
  initial begin
    SNES_reset_strobe = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK2);
    SNES_reset_strobe <= 1'b0;
  end

endmodule

// File: tb_cart_mem_arbiter.sv
module tb_cart_mem_arbiter;
  import snes_bus_pkg::*;
  import mem_pkg::*;

  localparam int SIG_MCU_RDY = 0;
  localparam int SIG_SA1_ROM = 1;
  localparam int SIG_SA1_RAM = 2;
  localparam int SIG_DEAD    = 3;
  localparam int SIG_RESET   = 4;
  localparam int RDY_LIMIT   = 200;

  logic                  CLK2;
  logic                  SNES_reset_strobe;
  logic                  snes_read_in;
  logic                  snes_write_in;
  logic                  snes_cpu_clk_in = 1'b0;
  logic [ADDR_W-1:0]     snes_map;
  logic                  is_rom;
  logic                  is_saveram;
  logic                  rom_hit;
  mem_req_t              mcu_req;
  mem_req_t              sa1_rom_req;
  mem_req_t              sa1_ram_req;
  logic [15:0]           rom_data_in;
  logic [7:0]            ram_data_in;
  logic [ROM_ADDR_W-1:0] rom_addr;
  logic                  rom_we;
  logic                  rom_bhe;
  logic                  rom_ble;
  logic [15:0]           rom_data_out;
  logic                  rom_data_oe;
  logic [RAM_ADDR_W-1:0] ram_addr;
  logic                  ram_we;
  logic [7:0]            ram_data_out;
  logic                  ram_data_oe;
  logic                  mcu_rdy;
  logic [7:0]            mcu_rdata;
  logic                  sa1_rom_rdy;
  logic [15:0]           sa1_rom_rdata;
  logic                  sa1_ram_rdy;
  logic [7:0]            sa1_ram_rdata;
  logic                  snes_dead;

  logic [15:0] rom_mem [0:63];
  logic [7:0]  ram_mem [0:63];
  int          rom_wr_cnt;
  logic        cpu_run = 1'b1;
  logic [2:0]  cpu_div = 3'd0;
  logic [31:0] lfsr;
  int          errors;
  int          timeouts;

  tb_clock #(.PERIOD(4), .RESET_CYCLES(3)) u_tb_clock (.CLK2, .SNES_reset_strobe);

  cart_mem_arbiter u_cart_mem_arbiter (.*);

  // --------------------------------------------------------------------------
  // memory models and console clock
  // --------------------------------------------------------------------------
  assign rom_data_in = rom_mem[rom_addr[5:0]];
  assign ram_data_in = ram_mem[ram_addr[5:0]];

  // lane enables are active low
  always @(posedge CLK2) begin
    if (SNES_reset_strobe) begin
      rom_wr_cnt <= 0;
      for (int i = 0; i < 64; i++) begin
        rom_mem[i] <= 16'h3c5a ^ (16'(i) * 16'h0107);
        ram_mem[i] <= 8'ha7 ^ (8'(i) * 8'h1d);
      end
    end else begin
      if (!rom_we) begin
        rom_wr_cnt <= rom_wr_cnt + 1;
        // data only lands while the cart drives the bus
        if (rom_data_oe) begin
          if (!rom_bhe) rom_mem[rom_addr[5:0]][15:8] <= rom_data_out[15:8];
          if (!rom_ble) rom_mem[rom_addr[5:0]][7:0] <= rom_data_out[7:0];
        end
      end
      if (!ram_we && ram_data_oe) begin
        ram_mem[ram_addr[5:0]] <= ram_data_out;
      end
    end
  end

  // cpu clock at one twelfth of CLK2 and held low when stopped
  always @(posedge CLK2) begin
    if (SNES_reset_strobe || !cpu_run) begin
      cpu_div         <= 3'd0;
      snes_cpu_clk_in <= 1'b0;
    end else if (cpu_div == 3'd5) begin
      cpu_div         <= 3'd0;
      snes_cpu_clk_in <= ~snes_cpu_clk_in;
    end else begin
      cpu_div <= cpu_div + 3'd1;
    end
  end

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_byte(output logic [7:0] val);
    val = 8'h00;
    for (int b = 0; b < 8; b++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  function automatic logic level_of(input int which);
    case (which)
      SIG_MCU_RDY: return mcu_rdy;
      SIG_SA1_ROM: return sa1_rom_rdy;
      SIG_SA1_RAM: return sa1_ram_rdy;
      SIG_DEAD:    return snes_dead;
      default:     return SNES_reset_strobe;
    endcase
  endfunction

  // after a timeout every later wait returns at once
  task automatic wait_level(input int which, input logic level, input int limit,
                            input string what);
    int   n;
    logic hit;
    n   = 0;
    hit = (timeouts != 0);
    while (!hit && n < limit) begin
      @(negedge CLK2);
      hit = (level_of(which) == level);
      n++;
    end
    if (!hit) begin
      timeouts++;
      $display("timeout waiting for %s", what);
    end
  endtask

  task automatic compare_hex(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (timeouts == 0) begin
      assert (got == exp) else begin
        errors++;
        $display("error: %s = %h, expected %h", name, got, exp);
      end
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    if (timeouts == 0) begin
      assert (cond) else begin
        errors++;
        $display("%s", what);
      end
    end
  endtask

  task automatic mcu_access(input logic is_wr, input logic [ADDR_W-1:0] addr,
                            input logic [7:0] wdata, output logic [7:0] rdata);
    wait_level(SIG_MCU_RDY, 1'b1, RDY_LIMIT, "mcu_rdy before a request");
    @(posedge CLK2);
    mcu_req.rd    <= ~is_wr;
    mcu_req.wr    <= is_wr;
    mcu_req.word  <= 1'b0;
    mcu_req.addr  <= addr;
    mcu_req.wdata <= {8'h00, wdata};
    @(posedge CLK2);
    mcu_req.rd <= 1'b0;
    mcu_req.wr <= 1'b0;
    wait_level(SIG_MCU_RDY, 1'b1, RDY_LIMIT, "mcu_rdy to rise");
    rdata = mcu_rdata;
  endtask

  task automatic sa1_rom_read(input logic [ADDR_W-1:0] addr, output logic [15:0] rdata);
    wait_level(SIG_SA1_ROM, 1'b1, RDY_LIMIT, "sa1_rom_rdy before a request");
    @(posedge CLK2);
    sa1_rom_req.rd   <= 1'b1;
    sa1_rom_req.word <= 1'b1;
    sa1_rom_req.addr <= addr;
    @(posedge CLK2);
    sa1_rom_req.rd <= 1'b0;
    wait_level(SIG_SA1_ROM, 1'b1, RDY_LIMIT, "sa1_rom_rdy to rise");
    rdata = sa1_rom_rdata;
  endtask

  task automatic sa1_ram_access(input logic is_wr, input logic [ADDR_W-1:0] addr,
                                input logic [7:0] wdata, output logic [7:0] rdata);
    wait_level(SIG_SA1_RAM, 1'b1, RDY_LIMIT, "sa1_ram_rdy before a request");
    @(posedge CLK2);
    sa1_ram_req.rd    <= ~is_wr;
    sa1_ram_req.wr    <= is_wr;
    sa1_ram_req.addr  <= addr;
    sa1_ram_req.wdata <= {8'h00, wdata};
    @(posedge CLK2);
    sa1_ram_req.rd <= 1'b0;
    sa1_ram_req.wr <= 1'b0;
    wait_level(SIG_SA1_RAM, 1'b1, RDY_LIMIT, "sa1_ram_rdy to rise");
    rdata = sa1_ram_rdata;
  endtask

  // --------------------------------------------------------------------------
  // directed tests
  // --------------------------------------------------------------------------
  task automatic check_reset_state();
    compare_hex("mcu_rdy", 32'(mcu_rdy), 32'h1);
    compare_hex("sa1_rom_rdy", 32'(sa1_rom_rdy), 32'h1);
    compare_hex("sa1_ram_rdy", 32'(sa1_ram_rdy), 32'h1);
    compare_hex("rom_we", 32'(rom_we), 32'h1);
    compare_hex("ram_we", 32'(ram_we), 32'h1);
    compare_hex("rom_data_oe", 32'(rom_data_oe), 32'h0);
    compare_hex("ram_data_oe", 32'(ram_data_oe), 32'h0);
    compare_hex("snes_dead", 32'(snes_dead), 32'h0);
  endtask

  task automatic mcu_rom_round_trip();
    logic [5:0] idx;
    logic [7:0] even_byte;
    logic [7:0] odd_byte;
    logic [7:0] rdata;
    for (int k = 0; k < 4; k++) begin
      idx = 6'(3 + 13 * k);
      random_byte(even_byte);
      random_byte(odd_byte);
      mcu_access(1'b1, {17'h0, idx, 1'b0}, even_byte, rdata);
      mcu_access(1'b1, {17'h0, idx, 1'b1}, odd_byte, rdata);
      // even byte in the high lane and odd byte in the low lane
      compare_hex("rom_mem", 32'(rom_mem[idx]), 32'({even_byte, odd_byte}));
      mcu_access(1'b0, {17'h0, idx, 1'b0}, 8'h00, rdata);
      compare_hex("mcu_rdata", 32'(rdata), 32'(even_byte));
      mcu_access(1'b0, {17'h0, idx, 1'b1}, 8'h00, rdata);
      compare_hex("mcu_rdata", 32'(rdata), 32'(odd_byte));
    end
  endtask

  task automatic mcu_ram_round_trip();
    logic [5:0] idx;
    logic [7:0] wbyte;
    logic [7:0] rdata;
    int         rom_writes;
    rom_writes = rom_wr_cnt;
    for (int k = 0; k < 4; k++) begin
      idx = 6'(5 + 19 * k);
      random_byte(wbyte);
      mcu_access(1'b1, {RAM_REGION, 13'h0, idx}, wbyte, rdata);
      compare_hex("ram_mem", 32'(ram_mem[idx]), 32'(wbyte));
      mcu_access(1'b0, {RAM_REGION, 13'h0, idx}, 8'h00, rdata);
      compare_hex("mcu_rdata", 32'(rdata), 32'(wbyte));
    end
    compare_hex("rom_wr_cnt", rom_wr_cnt, rom_writes);
  endtask

  task automatic sa1_accesses();
    logic [15:0] word;
    logic [7:0]  wbyte;
    logic [7:0]  rdata;
    sa1_rom_read({17'h0, 6'd21, 1'b1}, word);
    compare_hex("sa1_rom_rdata", 32'(word), 32'(rom_mem[21]));
    sa1_rom_read({17'h0, 6'd50, 1'b0}, word);
    compare_hex("sa1_rom_rdata", 32'(word), 32'({rom_mem[50][7:0], rom_mem[50][15:8]}));
    random_byte(wbyte);
    sa1_ram_access(1'b1, {18'h0, 6'd12}, wbyte, rdata);
    compare_hex("ram_mem", 32'(ram_mem[12]), 32'(wbyte));
    sa1_ram_access(1'b0, {18'h0, 6'd12}, 8'h00, rdata);
    compare_hex("sa1_ram_rdata", 32'(rdata), 32'(wbyte));
  endtask

  task automatic sa1_before_mcu();
    wait_level(SIG_MCU_RDY, 1'b1, RDY_LIMIT, "mcu_rdy before a request");
    wait_level(SIG_SA1_ROM, 1'b1, RDY_LIMIT, "sa1_rom_rdy before a request");
    @(posedge CLK2);
    sa1_rom_req.rd   <= 1'b1;
    sa1_rom_req.word <= 1'b1;
    sa1_rom_req.addr <= {17'h0, 6'd30, 1'b1};
    mcu_req.rd       <= 1'b1;
    mcu_req.addr     <= {17'h0, 6'd9, 1'b1};
    @(posedge CLK2);
    sa1_rom_req.rd <= 1'b0;
    mcu_req.rd     <= 1'b0;
    wait_level(SIG_SA1_ROM, 1'b1, RDY_LIMIT, "sa1_rom_rdy to rise");
    expect_true(!mcu_rdy, "mcu read finished before the sa1 read that outranks it");
    compare_hex("sa1_rom_rdata", 32'(sa1_rom_rdata), 32'(rom_mem[30]));
    wait_level(SIG_MCU_RDY, 1'b1, RDY_LIMIT, "mcu_rdy to rise");
    compare_hex("mcu_rdata", 32'(mcu_rdata), 32'(rom_mem[9][7:0]));
  endtask

  task automatic dead_console();
    logic [7:0] rdata;
    @(posedge CLK2);
    is_rom  <= 1'b1;
    cpu_run <= 1'b0;
    wait_level(SIG_DEAD, 1'b1, SNES_DEAD_TIMEOUT + 1000, "snes_dead to rise");
    // is_rom stays high so only the dead flag opens a slot
    mcu_access(1'b0, {17'h0, 6'd44, 1'b0}, 8'h00, rdata);
    compare_hex("mcu_rdata", 32'(rdata), 32'(rom_mem[44][15:8]));
    @(posedge CLK2);
    cpu_run <= 1'b1;
    wait_level(SIG_DEAD, 1'b0, 100, "snes_dead to fall");
    @(posedge CLK2);
    is_rom <= 1'b0;
  endtask

  initial begin
    lfsr     = 32'hfd2f_3f23;
    errors   = 0;
    timeouts = 0;
    snes_read_in  <= 1'b1;
    snes_write_in <= 1'b1;
    snes_map      <= '0;
    is_rom        <= 1'b0;
    is_saveram    <= 1'b0;
    rom_hit       <= 1'b0;
    mcu_req       <= '0;
    sa1_rom_req   <= '0;
    sa1_ram_req   <= '0;
    wait_level(SIG_RESET, 1'b0, 20, "reset release");
    check_reset_state();
    mcu_rom_round_trip();
    mcu_ram_round_trip();
    sa1_accesses();
    sa1_before_mcu();
    dead_console();
    $display("errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: files.f
snes_bus_pkg.sv
mem_pkg.sv
snes_bus_monitor.sv
mem_req_latch.sv
rom_port.sv
ram_port.sv
mcu_port.sv
cart_mem_arbiter.sv
tb_clock.sv
tb_cart_mem_arbiter.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_cart_mem_arbiter
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
